// File: hdl/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

	// Line geometry
	localparam int LINE_WORDS       = 8;
	localparam int WORD_OFFSET_BITS = 3;
	localparam int TAG_BITS         = 27;

	// AXI encodings used by the bridge
	localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;
	localparam logic [3:0] AXI_LEN_SINGLE = 4'd0;
	localparam logic [3:0] AXI_LEN_FILL   = 4'(LINE_WORDS - 1);

	typedef struct packed {
		logic [TAG_BITS-1:0]         tag;
		logic [WORD_OFFSET_BITS-1:0] word;
		logic [1:0]                  byte_off;
	} dbus_addr_split_t;

	// Same 32 bits seen as a flat byte address or split into line fields
	typedef union packed {
		logic [31:0]      flat;
		dbus_addr_split_t split;
	} dbus_addr_t;

	typedef struct packed {
		logic        read;
		logic        write;
		logic        uncached;
		dbus_addr_t  address;
		logic [31:0] wrdata;
		logic [3:0]  byte_en;
	} dbus_req_t;

	typedef struct packed {
		logic        stall;
		logic [31:0] rddata;
	} dbus_resp_t;

	// Master side, AXI3 lengths
	typedef struct packed {
		logic [31:0] araddr;
		logic [3:0]  arlen;
		logic [2:0]  arsize;
		logic [1:0]  arburst;
		logic        arvalid;
		logic [31:0] awaddr;
		logic [3:0]  awlen;
		logic [2:0]  awsize;
		logic [1:0]  awburst;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wlast;
		logic        wvalid;
		logic        rready;
		logic        bready;
	} axi_req_t;

	typedef struct packed {
		logic        arready;
		logic        awready;
		logic        wready;
		logic [31:0] rdata;
		logic        rlast;
		logic        rvalid;
		logic        bvalid;
	} axi_resp_t;

	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_DATA,
		WRITE_ADDR,
		WRITE_DATA,
		WRITE_RESP,
		DONE
	} bridge_state_t;

endpackage

`default_nettype wire

// File: hdl/dbus_req_stage.sv
`timescale 1ns/1ns
`default_nettype none

module dbus_req_stage (
	input  logic                clk,
	input  logic                rst,
	input  dbus_pkg::dbus_req_t dbus_req,
	input  logic                stall,
	output dbus_pkg::dbus_req_t pend,
	output logic                pend_valid
);

	import dbus_pkg::*;

	logic req_seen;

	// Only a real load or store makes the stage valid
	assign req_seen = dbus_req.read | dbus_req.write;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pend_valid <= 1'b0;
		end else if (!stall) begin
			pend_valid <= req_seen;
		end
	end

	// Request copy, the CPU is free to drop its fields once accepted
	always_ff @(posedge clk) begin
		if (!stall) begin
			pend <= dbus_req;
		end
	end

	// Bridge must see the same request for the whole AXI sequence
	a_pend_held: assert property (
		@(posedge clk) disable iff (rst)
		stall |=> $stable(pend.address.flat) && $stable(pend.wrdata)
			&& $stable(pend.byte_en) && $stable({pend.read, pend.write, pend.uncached})
	);

	// A stalled cycle never drops the pending request
	a_valid_held: assert property (
		@(posedge clk) disable iff (rst)
		stall |=> pend_valid
	);

endmodule

`default_nettype wire

// File: hdl/uncached_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module uncached_fsm (
	input  logic                    clk,
	input  logic                    rst,
	input  dbus_pkg::dbus_req_t     pend,
	input  logic                    pend_valid,
	input  logic                    hit,
	input  logic                    last_beat,
	input  dbus_pkg::axi_resp_t     axi_resp,
	output dbus_pkg::axi_req_t      axi_req,
	output logic                    stall,
	output logic                    fill_start,
	output logic                    beat_valid,
	output logic                    store_done,
	output logic [31:0]             single_rdata,
	output dbus_pkg::bridge_state_t state
);

	import dbus_pkg::*;

	bridge_state_t state_d;
	logic          need_read;
	logic          need_axi;
	logic [31:0]   line_addr;

	// Loads that cannot be served from the buffered line
	assign need_read = pend.read & (pend.uncached | ~hit);
	assign need_axi  = pend_valid & (pend.write | need_read);

	// Clear word and byte offset for the fill burst
	assign line_addr = {pend.address.flat[31:WORD_OFFSET_BITS+2], {(WORD_OFFSET_BITS+2){1'b0}}};

	always_comb begin
		state_d = state;
		unique case (state)
			IDLE: begin
				if (pend_valid && pend.write) begin
					state_d = WRITE_ADDR;
				end else if (pend_valid && need_read) begin
					state_d = READ_ADDR;
				end
			end
			READ_ADDR: begin
				if (axi_resp.arready) state_d = READ_DATA;
			end
			READ_DATA: begin
				if (axi_resp.rvalid && (pend.uncached || last_beat)) begin
					state_d = DONE;
				end
			end
			WRITE_ADDR: begin
				if (axi_resp.awready) state_d = WRITE_DATA;
			end
			WRITE_DATA: begin
				if (axi_resp.wready) state_d = WRITE_RESP;
			end
			WRITE_RESP: begin
				// Response code is not checked
				if (axi_resp.bvalid) state_d = DONE;
			end
			DONE: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_d;
		end
	end

	// Stall rises right after acceptance and drops on DONE
	assign stall = (state == IDLE) ? need_axi : (state != DONE);

	assign fill_start = (state == IDLE) && pend_valid && !pend.write && need_read
		&& !pend.uncached;
	assign beat_valid = (state == READ_DATA) && axi_resp.rvalid && !pend.uncached;
	assign store_done = (state == WRITE_RESP) && axi_resp.bvalid;

	always_comb begin
		// Uncached reads are single beats, misses fetch the whole line
		axi_req.araddr  = pend.uncached ? pend.address.flat : line_addr;
		axi_req.arlen   = pend.uncached ? AXI_LEN_SINGLE : AXI_LEN_FILL;
		axi_req.arsize  = AXI_SIZE_WORD;
		axi_req.arburst = AXI_BURST_INCR;
		axi_req.arvalid = (state == READ_ADDR);

		axi_req.awaddr  = pend.address.flat;
		axi_req.awlen   = AXI_LEN_SINGLE;
		axi_req.awsize  = AXI_SIZE_WORD;
		axi_req.awburst = AXI_BURST_INCR;
		axi_req.awvalid = (state == WRITE_ADDR);

		axi_req.wdata   = pend.wrdata;
		axi_req.wstrb   = pend.byte_en;
		axi_req.wvalid  = (state == WRITE_DATA);
		axi_req.wlast   = (state == WRITE_DATA);

		axi_req.rready  = (state == READ_DATA);
		axi_req.bready  = (state == WRITE_RESP);
	end

	// Single beat word for uncached loads
	always_ff @(posedge clk) begin
		if (state == READ_DATA && axi_resp.rvalid && pend.uncached) begin
			single_rdata <= axi_resp.rdata;
		end
	end

	a_arvalid_hold: assert property (
		@(posedge clk) disable iff (rst)
		axi_req.arvalid && !axi_resp.arready |=> axi_req.arvalid && $stable(axi_req.araddr)
	);

	// Write data only follows a completed AW handshake and is always the last beat
	a_wvalid_order: assert property (
		@(posedge clk) disable iff (rst)
		$rose(axi_req.wvalid) |-> axi_req.wlast && $past(axi_req.awvalid && axi_resp.awready)
	);

endmodule

`default_nettype wire

// File: hdl/beat_counter.sv
`timescale 1ns/1ns
`default_nettype none

module beat_counter (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  fill_start,
	input  logic                                  beat_valid,
	output logic [dbus_pkg::WORD_OFFSET_BITS-1:0] beat,
	output logic                                  last_beat
);

	import dbus_pkg::*;

	logic spent;

	assign last_beat = beat_valid && (beat == WORD_OFFSET_BITS'(LINE_WORDS - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			beat  <= '0;
			spent <= 1'b1;
		end else if (fill_start) begin
			beat  <= '0;
			spent <= 1'b0;
		end else if (beat_valid) begin
			beat  <= beat + 1'b1;
			spent <= last_beat;
		end
	end

	// No stray R beat once the burst is complete
	a_no_extra_beat: assert property (
		@(posedge clk) disable iff (rst)
		spent && !fill_start |-> !beat_valid
	);

endmodule

`default_nettype wire

// File: hdl/line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
	input  logic                                  clk,
	input  logic                                  rst,
	input  dbus_pkg::dbus_req_t                   pend,
	input  logic                                  fill_start,
	input  logic                                  beat_valid,
	input  logic [dbus_pkg::WORD_OFFSET_BITS-1:0] beat,
	input  logic                                  last_beat,
	input  logic [31:0]                           fill_data,
	input  logic                                  store_done,
	output logic                                  hit,
	output logic [31:0]                           line_rdata
);

	import dbus_pkg::*;

	logic [LINE_WORDS-1:0][31:0] words;
	logic [TAG_BITS-1:0]         line_tag;
	logic                        valid;
	logic                        filling;
	logic                        tag_match;

	assign tag_match  = valid && (line_tag == pend.address.split.tag);
	// Uncached loads always bypass the line
	assign hit        = tag_match && pend.read && !pend.uncached;
	assign line_rdata = words[pend.address.split.word];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid   <= 1'b0;
			filling <= 1'b0;
		end else if (fill_start) begin
			valid   <= 1'b0;
			filling <= 1'b1;
		end else if (filling && last_beat) begin
			valid   <= 1'b1;
			filling <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start) begin
			line_tag <= pend.address.split.tag;
		end
	end

	// Fill beats by index, stores merged per byte lane
	always_ff @(posedge clk) begin
		if (filling && beat_valid) begin
			words[beat] <= fill_data;
		end else if (store_done && tag_match) begin
			for (int i = 0; i < 4; i++) begin
				if (pend.byte_en[i]) begin
					words[pend.address.split.word][8*i +: 8] <= pend.wrdata[8*i +: 8];
				end
			end
		end
	end

	a_no_hit_in_fill: assert property (
		@(posedge clk) disable iff (rst)
		filling |-> !hit
	);

endmodule

`default_nettype wire

// File: hdl/dcache_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_bridge (
	input  logic                 clk,
	input  logic                 rst,
	input  dbus_pkg::dbus_req_t  dbus_req,
	output dbus_pkg::dbus_resp_t dbus_resp,
	output dbus_pkg::axi_req_t   axi_req,
	input  dbus_pkg::axi_resp_t  axi_resp
);

	import dbus_pkg::*;

	dbus_req_t                   pend;
	logic                        pend_valid;
	logic                        stall;
	logic                        hit;
	logic                        fill_start;
	logic                        beat_valid;
	logic                        store_done;
	logic                        last_beat;
	logic [WORD_OFFSET_BITS-1:0] beat;
	logic [31:0]                 single_rdata;
	logic [31:0]                 line_rdata;
	bridge_state_t               state;

	dbus_req_stage i_req_stage (
		.clk        (clk),
		.rst        (rst),
		.dbus_req   (dbus_req),
		.stall      (stall),
		.pend       (pend),
		.pend_valid (pend_valid)
	);

	uncached_fsm i_fsm (
		.clk          (clk),
		.rst          (rst),
		.pend         (pend),
		.pend_valid   (pend_valid),
		.hit          (hit),
		.last_beat    (last_beat),
		.axi_resp     (axi_resp),
		.axi_req      (axi_req),
		.stall        (stall),
		.fill_start   (fill_start),
		.beat_valid   (beat_valid),
		.store_done   (store_done),
		.single_rdata (single_rdata),
		.state        (state)
	);

	beat_counter i_beat_counter (
		.clk        (clk),
		.rst        (rst),
		.fill_start (fill_start),
		.beat_valid (beat_valid),
		.beat       (beat),
		.last_beat  (last_beat)
	);

	line_buffer i_line_buffer (
		.clk        (clk),
		.rst        (rst),
		.pend       (pend),
		.fill_start (fill_start),
		.beat_valid (beat_valid),
		.beat       (beat),
		.last_beat  (last_beat),
		.fill_data  (axi_resp.rdata),
		.store_done (store_done),
		.hit        (hit),
		.line_rdata (line_rdata)
	);

	always_comb begin
		dbus_resp.stall  = stall;
		dbus_resp.rddata = pend.uncached ? single_rdata : line_rdata;
	end

	// A finished miss leaves the requested line resident
	a_fill_resident: assert property (
		@(posedge clk) disable iff (rst)
		state == DONE && pend.read && !pend.write && !pend.uncached |-> hit
	);

endmodule

`default_nettype wire

// File: testbench/axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model (
	input  logic                clk,
	input  logic                rst,
	input  logic                random_delay,
	input  dbus_pkg::axi_req_t  axi_req,
	output dbus_pkg::axi_resp_t axi_resp
);

	import dbus_pkg::*;

	// 1 KB of word storage, byte address bits 9:2
	logic [31:0] mem [0:255];
	logic [31:0] lfsr;
	int          read_count;
	int          write_count;
	int          protocol_errors;
	logic [31:0] last_ar_addr;
	logic [3:0]  last_ar_len;
	logic [3:0]  last_aw_len;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// Ready and valid delay of 0 to 3 cycles
	function automatic int pick_delay();
		logic [1:0] d;
		if (!random_delay) return 0;
		d[0] = next_random_bit();
		d[1] = next_random_bit();
		return d;
	endfunction

	task automatic next_cycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic serve_read();
		logic [31:0] addr;
		logic [3:0]  len;
		addr = axi_req.araddr;
		len  = axi_req.arlen;
		// Word size and INCR bursts only
		assert (axi_req.arsize == 3'd2 && axi_req.arburst == 2'b01) else begin
			$display("AXI model: read request with an unexpected size or burst type");
			protocol_errors++;
		end
		last_ar_addr = addr;
		last_ar_len  = len;
		read_count++;
		next_cycles(pick_delay() + 1);
		axi_resp.arready = 1'b1;
		next_cycles(1);
		axi_resp.arready = 1'b0;
		for (int i = 0; i <= len; i++) begin
			axi_resp.rvalid = 1'b0;
			next_cycles(pick_delay());
			axi_resp.rdata  = mem[(addr[9:2] + i) % 256];
			axi_resp.rlast  = (i == len);
			axi_resp.rvalid = 1'b1;
			@(negedge clk);
			assert (axi_req.rready) else begin
				$display("AXI model: read data beat presented while rready was low");
				protocol_errors++;
			end
			next_cycles(1);
		end
		axi_resp.rvalid = 1'b0;
		axi_resp.rlast  = 1'b0;
	endtask

	task automatic serve_write();
		logic [7:0] idx;
		idx = axi_req.awaddr[9:2];
		assert (axi_req.awsize == 3'd2 && axi_req.awburst == 2'b01) else begin
			$display("AXI model: write request with an unexpected size or burst type");
			protocol_errors++;
		end
		last_aw_len = axi_req.awlen;
		next_cycles(pick_delay() + 1);
		axi_resp.awready = 1'b1;
		next_cycles(1);
		axi_resp.awready = 1'b0;
		next_cycles(pick_delay());
		axi_resp.wready = 1'b1;
		@(negedge clk);
		assert (axi_req.wvalid && axi_req.wlast) else begin
			$display("AXI model: write data beat accepted without wvalid and wlast");
			protocol_errors++;
		end
		for (int b = 0; b < 4; b++) begin
			if (axi_req.wstrb[b]) begin
				mem[idx][8*b +: 8] = axi_req.wdata[8*b +: 8];
			end
		end
		write_count++;
		next_cycles(1);
		axi_resp.wready = 1'b0;
		next_cycles(pick_delay());
		axi_resp.bvalid = 1'b1;
		@(negedge clk);
		assert (axi_req.bready) else begin
			$display("AXI model: write response presented while bready was low");
			protocol_errors++;
		end
		next_cycles(1);
		axi_resp.bvalid = 1'b0;
	endtask

	initial begin
		axi_resp        = '0;
		lfsr            = 32'hfbe;
		read_count      = 0;
		write_count     = 0;
		protocol_errors = 0;
		last_ar_addr    = '0;
		last_ar_len     = '0;
		last_aw_len     = '0;
		forever begin
			// Requests are picked up mid-cycle, one at a time
			@(negedge clk);
			if (!rst && axi_req.arvalid) begin
				serve_read();
			end else if (!rst && axi_req.awvalid) begin
				serve_write();
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_dcache_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache_bridge;

	import dbus_pkg::*;

	localparam int RESET_CYCLES  = 4;
	localparam int RANDOM_OPS    = 64;
	localparam int REQUEST_COUNT = 1 + 2 + 9 + 2 + RANDOM_OPS;

	logic        clk;
	logic        rst;
	logic        random_delay;
	dbus_req_t   dbus_req;
	dbus_resp_t  dbus_resp;
	axi_req_t    axi_req;
	axi_resp_t   axi_resp;

	logic [31:0] ref_mem [0:255];
	logic [31:0] lfsr;
	// Line the bridge should hold, tracked from the request history
	logic [26:0] filled_tag;
	logic        filled;
	int          expected_ar;
	int          error_count;

	dcache_bridge i_dcache_bridge (
		.clk       (clk),
		.rst       (rst),
		.dbus_req  (dbus_req),
		.dbus_resp (dbus_resp),
		.axi_req   (axi_req),
		.axi_resp  (axi_resp)
	);

	axi_mem_model i_axi_mem (
		.clk          (clk),
		.rst          (rst),
		.random_delay (random_delay),
		.axi_req      (axi_req),
		.axi_resp     (axi_resp)
	);

	always #4 clk = ~clk;

	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], next_random_bit()};
		end
		return value;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] be);
		logic [31:0] result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
		end
		return result;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
			error_count++;
		end
	endtask

	// One CPU load or store, checked against the reference memory
	task automatic access(input logic is_write, input logic uncached, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] be, output logic [31:0] rdata);
		logic       miss;
		logic       stalled;
		logic [7:0] idx;
		idx  = addr[9:2];
		miss = uncached || !filled || (addr[31:5] != filled_tag);
		dbus_req.read         = !is_write;
		dbus_req.write        = is_write;
		dbus_req.uncached     = uncached;
		dbus_req.address.flat = addr;
		dbus_req.wrdata       = wdata;
		dbus_req.byte_en      = be;
		@(negedge clk);
		while (dbus_resp.stall) @(negedge clk);
		@(posedge clk);
		#1;
		dbus_req.read  = 1'b0;
		dbus_req.write = 1'b0;
		// First cycle after acceptance
		@(negedge clk);
		stalled = dbus_resp.stall;
		while (dbus_resp.stall) @(negedge clk);
		rdata = dbus_resp.rddata;
		if (is_write) begin
			ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
			check_value("stall", stalled, 1'b1);
		end else begin
			check_value("rddata", rdata, ref_mem[idx]);
			check_value("stall", stalled, miss);
			if (miss) expected_ar++;
			if (!uncached) begin
				filled     = 1'b1;
				filled_tag = addr[31:5];
			end
		end
		@(posedge clk);
		#1;
	endtask

	task automatic compare_memory();
		for (int i = 0; i < 256; i++) begin
			check_value($sformatf("mem[%0d]", i), i_axi_mem.mem[i], ref_mem[i]);
		end
	endtask

	task automatic reset_test();
		int          reads_before;
		logic [31:0] rdata;
		@(negedge clk);
		check_value("stall", dbus_resp.stall, 1'b0);
		check_value("arvalid", axi_req.arvalid, 1'b0);
		check_value("awvalid", axi_req.awvalid, 1'b0);
		check_value("wvalid", axi_req.wvalid, 1'b0);
		check_value("rready", axi_req.rready, 1'b0);
		check_value("bready", axi_req.bready, 1'b0);
		@(posedge clk);
		#1;
		reads_before = i_axi_mem.read_count;
		// Buffer starts invalid so this must go to AXI
		access(1'b0, 1'b0, 32'h0000_0044, '0, '0, rdata);
		check_value("read_count", i_axi_mem.read_count, reads_before + 1);
	endtask

	task automatic uncached_test();
		int          reads_before;
		int          writes_before;
		logic [31:0] old_word;
		logic [31:0] rdata;
		reads_before  = i_axi_mem.read_count;
		writes_before = i_axi_mem.write_count;
		access(1'b0, 1'b1, 32'h0000_0104, '0, '0, rdata);
		check_value("read_count", i_axi_mem.read_count, reads_before + 1);
		check_value("arlen", i_axi_mem.last_ar_len, 4'd0);
		check_value("araddr", i_axi_mem.last_ar_addr, 32'h0000_0104);
		old_word = ref_mem[66];
		access(1'b1, 1'b1, 32'h0000_0108, 32'hdead_beef, 4'b0101, rdata);
		check_value("mem[66]", i_axi_mem.mem[66], {old_word[31:24], 8'had, old_word[15:8], 8'hef});
		check_value("write_count", i_axi_mem.write_count, writes_before + 1);
		check_value("awlen", i_axi_mem.last_aw_len, 4'd0);
	endtask

	task automatic miss_then_hits_test();
		int          reads_before;
		logic [31:0] rdata;
		reads_before = i_axi_mem.read_count;
		access(1'b0, 1'b0, 32'h0000_0208, '0, '0, rdata);
		check_value("read_count", i_axi_mem.read_count, reads_before + 1);
		check_value("araddr", i_axi_mem.last_ar_addr, 32'h0000_0200);
		check_value("arlen", i_axi_mem.last_ar_len, 4'd7);
		for (int w = 0; w < 8; w++) begin
			access(1'b0, 1'b0, 32'h0000_0200 + 4 * w, '0, '0, rdata);
		end
		check_value("read_count", i_axi_mem.read_count, reads_before + 1);
	endtask

	task automatic write_through_test();
		int          reads_before;
		logic [31:0] old_word;
		logic [31:0] merged;
		logic [31:0] rdata;
		old_word     = ref_mem[133];
		merged       = {8'h12, old_word[23:8], 8'h78};
		reads_before = i_axi_mem.read_count;
		access(1'b1, 1'b0, 32'h0000_0214, 32'h1234_5678, 4'b1001, rdata);
		check_value("mem[133]", i_axi_mem.mem[133], merged);
		access(1'b0, 1'b0, 32'h0000_0214, '0, '0, rdata);
		check_value("rddata", rdata, merged);
		check_value("read_count", i_axi_mem.read_count, reads_before);
	endtask

	task automatic random_sequence_test();
		int          reads_before;
		int          ar_before;
		logic        is_write;
		logic        uncached;
		logic [31:0] line_sel;
		logic [31:0] word;
		logic [31:0] wdata;
		logic [3:0]  be;
		logic [31:0] rdata;
		random_delay = 1'b1;
		reads_before = i_axi_mem.read_count;
		ar_before    = expected_ar;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			is_write = next_random_bit();
			uncached = (random_bits(2) == 0);
			line_sel = random_bits(2) % 3;
			word     = random_bits(3);
			wdata    = random_bits(32);
			be       = random_bits(4);
			access(is_write, uncached, 32'h0000_0300 + 32'h40 * line_sel + 4 * word,
				wdata, be, rdata);
		end
		check_value("read_count", i_axi_mem.read_count - reads_before, expected_ar - ar_before);
		compare_memory();
		random_delay = 1'b0;
	endtask

	// Watchdog
	initial begin
		repeat (RESET_CYCLES + 200 * REQUEST_COUNT) @(posedge clk);
		$display("Timed out waiting for the DUT to finish a request");
		$display("tests failed");
		$finish;
	end

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		random_delay = 1'b0;
		dbus_req     = '0;
		lfsr         = 32'hfbe;
		filled       = 1'b0;
		filled_tag   = '0;
		expected_ar  = 0;
		error_count  = 0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i]        = fill_word(32'(i) << 2);
			i_axi_mem.mem[i] = ref_mem[i];
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		reset_test();
		uncached_test();
		miss_then_hits_test();
		write_through_test();
		random_sequence_test();
		check_value("protocol_errors", i_axi_mem.protocol_errors, 0);

		$display("Run complete with %0d errors", error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hdl/dbus_pkg.sv
hdl/dbus_req_stage.sv
hdl/uncached_fsm.sv
hdl/beat_counter.sv
hdl/line_buffer.sv
hdl/dcache_bridge.sv
testbench/axi_mem_model.sv
testbench/tb_dcache_bridge.sv
